// ==== hdl/comb_pkg.sv ====
// Widths, types and constants of the feedback comb filter
// Stage and memory write structs shared by all pipeline stages

`default_nettype none

package comb_pkg;

  localparam int SAMPLE_BITS = 16;
  localparam int Q_BITS      = 14;
  localparam int SCALED_BITS = SAMPLE_BITS + 2;
  localparam int ADDR_BITS   = 8;
  localparam int DEPTH       = 256;
  localparam int MIN_DELAY   = 4;

  typedef logic signed [SAMPLE_BITS-1:0] sample_t;
  // Gain in Q2.14
  typedef logic signed [SAMPLE_BITS-1:0] gain_t;
  typedef logic        [ADDR_BITS-1:0]   addr_t;
  typedef logic        [ADDR_BITS-1:0]   delay_t;
  typedef logic signed [SCALED_BITS-1:0] scaled_t;

  // Saturation limits of the output sum
  localparam sample_t SAMPLE_MAX = sample_t'(16'sh7fff);
  localparam sample_t SAMPLE_MIN = sample_t'(16'sh8000);

  // Travels with each sample through the pipeline
  typedef struct packed {
    logic    valid;
    sample_t x;
    gain_t   gain;
    addr_t   wr_addr;
  } stage_t;

  typedef struct packed {
    logic    en;
    addr_t   addr;
    sample_t data;
  } ram_wr_t;

  typedef enum logic {
    CLEAR_RUN_E,
    CLEAR_DONE_E
  } clear_state_t;

endpackage

`default_nettype wire

// ==== hdl/comb_delay_ctrl.sv ====
// Delay memory clear sweep after reset
// Delay and gain configuration, write pointer and read address (stage 0)

`timescale 1ns/1ps
`default_nettype none

module comb_delay_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire comb_pkg::sample_t  x,
  input  wire                     x_valid,
  input  wire                     cfg_load,
  input  wire comb_pkg::delay_t   cfg_delay,
  input  wire comb_pkg::gain_t    cfg_gain,
  output logic                    ready,
  output comb_pkg::addr_t         rd_addr,
  output comb_pkg::ram_wr_t       clr_wr,
  output comb_pkg::stage_t        s0
);

  comb_pkg::clear_state_t clear_state;
  comb_pkg::addr_t        clr_addr;
  comb_pkg::delay_t       delay_q;
  comb_pkg::gain_t        gain_q;
  comb_pkg::addr_t        wr_ptr;
  comb_pkg::stage_t       in_stage;
  comb_pkg::delay_t       in_delay;

  ////////////////////
  // Clear sweep
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clear_state <= comb_pkg::CLEAR_RUN_E;
      clr_addr    <= '0;
    end else if (clear_state == comb_pkg::CLEAR_RUN_E) begin
      clr_addr <= clr_addr + 1'b1;
      // Last address written on this edge
      if (clr_addr == comb_pkg::addr_t'(comb_pkg::DEPTH - 1)) begin
        clear_state <= comb_pkg::CLEAR_DONE_E;
      end
    end
  end

  assign ready = (clear_state == comb_pkg::CLEAR_DONE_E);

  always_comb begin
    clr_wr.en   = (clear_state == comb_pkg::CLEAR_RUN_E);
    clr_wr.addr = clr_addr;
    clr_wr.data = '0;
  end

  ////////////////////
  // Configuration and input capture
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_q  <= comb_pkg::delay_t'(comb_pkg::MIN_DELAY);
      gain_q   <= '0;
      wr_ptr   <= '0;
      in_stage <= '0;
      in_delay <= '0;
    end else begin
      if (cfg_load) begin
        // Shorter delays would read ahead of the pending feedback write
        if (cfg_delay < comb_pkg::delay_t'(comb_pkg::MIN_DELAY)) begin
          delay_q <= comb_pkg::delay_t'(comb_pkg::MIN_DELAY);
        end else begin
          delay_q <= cfg_delay;
        end
        gain_q <= cfg_gain;
      end
      in_stage.valid <= x_valid && ready;
      if (x_valid && ready) begin
        in_stage.x       <= x;
        in_stage.gain    <= gain_q;
        in_stage.wr_addr <= wr_ptr;
        in_delay         <= delay_q;
        wr_ptr           <= wr_ptr + 1'b1;
      end
    end
  end

  // Stage 0, the read address wraps modulo DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
      s0      <= '0;
    end else begin
      rd_addr <= in_stage.wr_addr - in_delay;
      s0      <= in_stage;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/comb_delay_ram.sv ====
// Circular delay memory with registered read (stage 1)
// Write port selects clear writes over feedback writes

`timescale 1ns/1ps
`default_nettype none

module comb_delay_ram (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire comb_pkg::addr_t    rd_addr,
  input  wire comb_pkg::ram_wr_t  clr_wr,
  input  wire comb_pkg::ram_wr_t  fb_wr,
  input  wire comb_pkg::stage_t   s0,
  output comb_pkg::sample_t       rd_data,
  output comb_pkg::stage_t        s1
);

  comb_pkg::sample_t mem [comb_pkg::DEPTH];
  comb_pkg::ram_wr_t wr;

  // Clear and feedback never overlap, no sample is taken during the sweep
  assign wr = clr_wr.en ? clr_wr : fb_wr;

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    rd_data <= mem[rd_addr];
  end

  // Keeps the sample aligned with its read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= '0;
    end else begin
      s1 <= s0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/comb_gain_stage.sv ====
// Feedback gain multiply (stage 2)
// Scales the delayed output back from Q2.14 with floor rounding

`timescale 1ns/1ps
`default_nettype none

module comb_gain_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire comb_pkg::stage_t   s1,
  input  wire comb_pkg::sample_t  rd_data,
  output comb_pkg::stage_t        s2,
  output comb_pkg::scaled_t       scaled
);

  logic signed [2*comb_pkg::SAMPLE_BITS-1:0] product;

  // Full precision, both operands signed
  assign product = rd_data * s1.gain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2     <= '0;
      scaled <= '0;
    end else begin
      s2 <= s1;
      // Arithmetic shift rounds toward minus infinity, result fits in 18 bits
      scaled <= comb_pkg::scaled_t'(product >>> comb_pkg::Q_BITS);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/comb_sum_stage.sv ====
// Input plus scaled feedback with saturation (stage 3)
// Output register and feedback write into the delay memory

`timescale 1ns/1ps
`default_nettype none

module comb_sum_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire comb_pkg::stage_t   s2,
  input  wire comb_pkg::scaled_t  scaled,
  output comb_pkg::sample_t       y,
  output logic                    y_valid,
  output comb_pkg::ram_wr_t       fb_wr
);

  logic signed [comb_pkg::SCALED_BITS:0] sum;
  comb_pkg::sample_t                     sum_sat;

  // One bit of headroom over the scaled term
  assign sum = s2.x + scaled;

  always_comb begin
    if (sum > comb_pkg::SAMPLE_MAX) begin
      sum_sat = comb_pkg::SAMPLE_MAX;
    end else if (sum < comb_pkg::SAMPLE_MIN) begin
      sum_sat = comb_pkg::SAMPLE_MIN;
    end else begin
      sum_sat = comb_pkg::sample_t'(sum);
    end
  end

  ////////////////////
  // Output and feedback
  ////////////////////

  // The write lands one edge later, ahead of any read with D >= 4
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y       <= '0;
      y_valid <= 1'b0;
      fb_wr   <= '0;
    end else begin
      y_valid    <= s2.valid;
      fb_wr.en   <= s2.valid;
      fb_wr.addr <= s2.wr_addr;
      if (s2.valid) begin
        y          <= sum_sat;
        fb_wr.data <= sum_sat;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/comb_filter_top.sv ====
// Feedback comb filter top level, y(n) = x(n) + g*y(n-D)
// Connects the control, memory, gain and sum stages

`timescale 1ns/1ps
`default_nettype none

module comb_filter_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire comb_pkg::sample_t  x,
  input  wire                     x_valid,
  input  wire                     cfg_load,
  input  wire comb_pkg::delay_t   cfg_delay,
  input  wire comb_pkg::gain_t    cfg_gain,
  output comb_pkg::sample_t       y,
  output logic                    y_valid,
  output logic                    ready
);

  comb_pkg::addr_t   rd_addr;
  comb_pkg::ram_wr_t clr_wr;
  comb_pkg::ram_wr_t fb_wr;
  comb_pkg::stage_t  s0;
  comb_pkg::stage_t  s1;
  comb_pkg::stage_t  s2;
  comb_pkg::sample_t rd_data;
  comb_pkg::scaled_t scaled;

  comb_delay_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .x         (x),
    .x_valid   (x_valid),
    .cfg_load  (cfg_load),
    .cfg_delay (cfg_delay),
    .cfg_gain  (cfg_gain),
    .ready     (ready),
    .rd_addr   (rd_addr),
    .clr_wr    (clr_wr),
    .s0        (s0)
  );

  comb_delay_ram u_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_addr (rd_addr),
    .clr_wr  (clr_wr),
    .fb_wr   (fb_wr),
    .s0      (s0),
    .rd_data (rd_data),
    .s1      (s1)
  );

  comb_gain_stage u_gain (
    .clk     (clk),
    .rst_n   (rst_n),
    .s1      (s1),
    .rd_data (rd_data),
    .s2      (s2),
    .scaled  (scaled)
  );

  comb_sum_stage u_sum (
    .clk     (clk),
    .rst_n   (rst_n),
    .s2      (s2),
    .scaled  (scaled),
    .y       (y),
    .y_valid (y_valid),
    .fb_wr   (fb_wr)
  );

endmodule

`default_nettype wire

// ==== verif/tb_comb_filter.sv ====
// Directed testbench for the feedback comb filter
// Reference model with a delay history, latency check and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_comb_filter;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 4;
  // Samples over all tests plus idle cycles around each burst
  localparam int TEST_CYCLES  = 492 + 12 * 10;
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + comb_pkg::DEPTH + TEST_CYCLES);

  typedef struct packed {
    int                due;
    comb_pkg::sample_t y;
  } expect_t;

  logic              clk = 1'b0;
  logic              rst_n;
  comb_pkg::sample_t x;
  logic              x_valid;
  logic              cfg_load;
  comb_pkg::delay_t  cfg_delay;
  comb_pkg::gain_t   cfg_gain;
  comb_pkg::sample_t y;
  logic              y_valid;
  logic              ready;

  int                cycle = 0;
  logic [15:0]       lfsr_state;
  expect_t           exp_q [$];
  comb_pkg::sample_t out_q [$];

  // Reference model state
  int hist [comb_pkg::DEPTH];
  int m_wptr;
  int m_delay;
  int m_gain;

  comb_filter_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .x         (x),
    .x_valid   (x_valid),
    .cfg_load  (cfg_load),
    .cfg_delay (cfg_delay),
    .cfg_gain  (cfg_gain),
    .y         (y),
    .y_valid   (y_valid),
    .ready     (ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Helpers
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic comb_pkg::sample_t rand_sample();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[14:0], lfsr_state[0]};
    end
    return comb_pkg::sample_t'(w);
  endfunction

  // Floor scaling of the delayed output, then saturation to 16 bits
  function automatic int model_y(input int xin, input int past, input int gain);
    int sum;
    sum = xin + ((past * gain) >>> comb_pkg::Q_BITS);
    if (sum > 32767) begin
      return 32767;
    end
    if (sum < -32768) begin
      return -32768;
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  // Outputs and inputs are stable at the falling edge
  always @(negedge clk) begin
    int      rd;
    int      ye;
    expect_t e;
    if (y_valid) begin
      if (exp_q.size() == 0) begin
        stop_run("y_valid without a pending sample");
      end else begin
        check_value("output edge", cycle, exp_q[0].due);
        check_value("y", int'(y), int'(exp_q[0].y));
        out_q.push_back(y);
        void'(exp_q.pop_front());
      end
    end else if (exp_q.size() != 0 && cycle >= exp_q[0].due) begin
      stop_run("y_valid missing four cycles after an accepted sample");
    end
    if (x_valid && ready) begin
      rd = (m_wptr - m_delay + comb_pkg::DEPTH) % comb_pkg::DEPTH;
      ye = model_y(int'(x), hist[rd], m_gain);
      hist[m_wptr] = ye;
      m_wptr = (m_wptr + 1) % comb_pkg::DEPTH;
      // Taken on the next rising edge
      e.due = cycle + 1 + LATENCY;
      e.y   = comb_pkg::sample_t'(ye);
      exp_q.push_back(e);
    end
    if (cfg_load) begin
      m_delay = int'(cfg_delay);
      if (m_delay < comb_pkg::MIN_DELAY) begin
        m_delay = comb_pkg::MIN_DELAY;
      end
      m_gain = int'(cfg_gain);
    end
  end

  task automatic send_sample(input comb_pkg::sample_t v);
    @(posedge clk);
    x       <= v;
    x_valid <= 1'b1;
  endtask

  // Ends a burst and waits until every sample has come out
  task automatic end_burst();
    @(posedge clk);
    x_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic load_cfg(input int d, input int g);
    @(posedge clk);
    cfg_load  <= 1'b1;
    cfg_delay <= comb_pkg::delay_t'(d);
    cfg_gain  <= comb_pkg::gain_t'(g);
    @(posedge clk);
    cfg_load  <= 1'b0;
  endtask

  // Zero gain writes zeros over the next n history entries
  task automatic flush_history(input int n);
    load_cfg(4, 0);
    for (int i = 0; i < n; i++) begin
      send_sample('0);
    end
    end_burst();
  endtask

  ////////////////////
  // Tests
  ////////////////////

  // Called on the rising edge that ends the reset
  task automatic test_clear();
    int                rel;
    comb_pkg::sample_t sent [20];
    rst_n     <= 1'b1;
    x         <= 16'sd1234;
    x_valid   <= 1'b1;
    cfg_load  <= 1'b1;
    cfg_delay <= 8'd10;
    cfg_gain  <= 16'sd12288;
    @(negedge clk);
    rel = cycle;
    @(posedge clk);
    cfg_load <= 1'b0;
    repeat (8) @(posedge clk);
    x_valid <= 1'b0;
    while (!ready) begin
      @(negedge clk);
    end
    check_value("cycles until ready", cycle - rel, comb_pkg::DEPTH);
    out_q.delete();
    // The second ten outputs see the delay and gain loaded during the clear
    for (int i = 0; i < 20; i++) begin
      sent[i] = rand_sample();
      send_sample(sent[i]);
    end
    end_burst();
    for (int i = 0; i < 10; i++) begin
      check_value("output over cleared history", int'(out_q[i]), int'(sent[i]));
    end
  endtask

  task automatic test_impulse();
    int peaks [6] = '{8000, 6000, 4500, 3375, 2531, 1898};
    flush_history(16);
    load_cfg(10, 12288);
    out_q.delete();
    send_sample(16'sd8000);
    for (int i = 1; i < 60; i++) begin
      send_sample('0);
    end
    end_burst();
    for (int i = 0; i < 60; i++) begin
      check_value("impulse response", int'(out_q[i]), (i % 10 == 0) ? peaks[i / 10] : 0);
    end
  endtask

  task automatic test_clamp();
    comb_pkg::sample_t pattern [20];
    comb_pkg::sample_t run_a [20];
    for (int i = 0; i < 20; i++) begin
      pattern[i] = rand_sample() >>> 3;
    end
    for (int run = 0; run < 2; run++) begin
      flush_history(8);
      load_cfg((run == 0) ? 1 : comb_pkg::MIN_DELAY, 8192);
      out_q.delete();
      for (int i = 0; i < 20; i++) begin
        send_sample(pattern[i]);
      end
      end_burst();
      for (int i = 0; i < 20; i++) begin
        if (run == 0) begin
          run_a[i] = out_q[i];
        end else begin
          check_value("delay 1 against delay 4", int'(run_a[i]), int'(out_q[i]));
        end
      end
    end
  endtask

  task automatic test_saturation();
    int level;
    for (int s = 0; s < 2; s++) begin
      level = (s == 0) ? 30000 : -30000;
      flush_history(8);
      load_cfg(4, 24576);
      out_q.delete();
      for (int i = 0; i < 12; i++) begin
        send_sample(comb_pkg::sample_t'(level));
      end
      end_burst();
      // From the fifth sample on the feedback overflows
      for (int i = 0; i < 12; i++) begin
        check_value("saturated output", int'(out_q[i]),
                    (i < 4) ? level : ((s == 0) ? 32767 : -32768));
      end
    end
  endtask

  task automatic test_stream();
    load_cfg(23, 12288);
    out_q.delete();
    for (int i = 0; i < 300; i++) begin
      @(posedge clk);
      x         <= rand_sample();
      x_valid   <= 1'b1;
      cfg_load  <= (i == 150);
      cfg_delay <= 8'd200;
      cfg_gain  <= -16'sd9830;
    end
    end_burst();
    check_value("streamed output count", out_q.size(), 300);
  endtask

  initial begin
    rst_n      = 1'b0;
    x          = '0;
    x_valid    = 1'b0;
    cfg_load   = 1'b0;
    cfg_delay  = '0;
    cfg_gain   = '0;
    lfsr_state = 16'd45381;
    m_wptr     = 0;
    m_delay    = comb_pkg::MIN_DELAY;
    m_gain     = 0;
    foreach (hist[i]) begin
      hist[i] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    test_clear();
    test_impulse();
    test_clamp();
    test_saturation();
    test_stream();
    repeat (4) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/comb_pkg.sv
hdl/comb_delay_ctrl.sv
hdl/comb_delay_ram.sv
hdl/comb_gain_stage.sv
hdl/comb_sum_stage.sv
hdl/comb_filter_top.sv
verif/tb_comb_filter.sv

// ==== Makefile ====
# Verilator build and run of the comb filter testbench

VERILATOR ?= verilator
TOP       ?= tb_comb_filter
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "sim passed" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
